/* rd_ig_pkg.sv */
/*
  widths, packet layouts and the client remap table of the read ingress converter
  rd_cmd_t keeps the split-command packing with axid in the low bits
*/
package rd_ig_pkg;

  // ==============================
  // widths
  // ==============================

  // byte address into memory
  localparam int mem_addr_width = 32;
  // one memory atom is 32 bytes
  localparam int atomic_log2 = 5;
  localparam int num_read_clients = 10;
  // up to 256 beats outstanding, plus margin
  localparam int os_cnt_width = 9;
  localparam int os_limit_width = 8;

  // ==============================
  // plain vector types
  // ==============================

  typedef logic [mem_addr_width-1:0] mem_addr_t;
  typedef logic [3:0]                axid_t;
  // size in atoms, minus one
  typedef logic [2:0]                cmd_size_t;
  typedef logic [1:0]                ar_len_t;
  typedef logic [3:0]                thread_id_t;
  typedef logic [os_cnt_width-1:0]   os_cnt_t;
  typedef logic [os_limit_width-1:0] os_limit_t;

  // ==============================
  // packets
  // ==============================

  // split read command, msb first
  typedef struct packed {
    logic      ftran;
    logic      ltran;
    logic      odd;
    logic      swizzle;
    cmd_size_t size;
    mem_addr_t addr;
    axid_t     axid;
  } rd_cmd_t;

  // read address beat toward the bus
  typedef struct packed {
    axid_t     axid;
    mem_addr_t addr;
    ar_len_t   len;
  } ar_cmd_t;

  // context entry, read back by the egress side
  typedef struct packed {
    logic    ltran;
    logic    odd;
    logic    swizzle;
    ar_len_t lens;
  } cq_entry_t;

  // axid per context-queue thread
  // position in the table is the thread id
  localparam axid_t client_remap [0:num_read_clients-1] = '{
    4'd0, 4'd8, 4'd9, 4'd3, 4'd2, 4'd4, 4'd1, 4'd5, 4'd7, 4'd6
  };

endpackage

/* rd_ig_credit_ctrl.sv */
/*
  outstanding read beat credits and admission interlock
  assumes eg2ig_axi_vld never retires more beats than were issued
*/
`timescale 1ns/1ps

module rd_ig_credit_ctrl (
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  logic                 req_valid,
  input  rd_ig_pkg::ar_len_t   ar_len,
  input  logic                 cq_wr_prdy,
  input  logic                 pipe_in_ready,
  input  logic                 eg2ig_axi_vld,
  input  rd_ig_pkg::os_limit_t reg2dp_rd_os_cnt,
  output logic                 req_ready,
  output logic                 cq_wr_pvld,
  output logic                 pipe_in_valid
);

  import rd_ig_pkg::*;

  // one bit wider than the counter, room for the compare
  localparam int ext_width = os_cnt_width + 1;

  logic                 eg2ig_axi_vld_d;
  os_cnt_t              os_cnt;
  os_cnt_t              os_cnt_nxt;
  logic [2:0]           cmd_beats;
  logic [2:0]           inp_add;
  logic [ext_width-1:0] os_inp_nxt;
  logic [ext_width-1:0] limit_ext;
  logic                 os_cnt_full;
  logic                 os_cnt_add_en;
  logic                 os_cnt_sub_en;
  logic [2:0]           os_cnt_add;

  // ==============================
  // return delay
  // ==============================

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      eg2ig_axi_vld_d <= 1'b0;
    end else begin
      eg2ig_axi_vld_d <= eg2ig_axi_vld;
    end
  end

  // ==============================
  // full check
  // ==============================

  // beats in one command, len plus 1
  assign cmd_beats = {1'b0, ar_len} + 3'd1;

  // pending command counts only while it is offered
  assign inp_add = req_valid ? cmd_beats : 3'd0;

  // count if this command went in, minus the delayed return
  assign os_inp_nxt = ext_width'({1'b0, os_cnt}) + ext_width'(inp_add)
                    - ext_width'(eg2ig_axi_vld_d);

  // limit plus one beat of slack
  assign limit_ext   = ext_width'(reg2dp_rd_os_cnt) + ext_width'(1);
  assign os_cnt_full = os_inp_nxt > limit_ext;

  // ==============================
  // handshakes
  // ==============================

  // each side waits for the other, a command lands in both or neither
  assign pipe_in_valid = req_valid & cq_wr_prdy & !os_cnt_full;
  assign cq_wr_pvld    = req_valid & pipe_in_ready & !os_cnt_full;
  assign req_ready     = pipe_in_ready & cq_wr_prdy & !os_cnt_full;

  // ==============================
  // outstanding counter
  // ==============================

  assign os_cnt_add_en = pipe_in_valid & pipe_in_ready;
  assign os_cnt_sub_en = eg2ig_axi_vld_d;
  assign os_cnt_add    = os_cnt_add_en ? cmd_beats : 3'd0;

  assign os_cnt_nxt = os_cnt + os_cnt_t'(os_cnt_add) - os_cnt_t'(os_cnt_sub_en);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      os_cnt <= '0;
    end else if (os_cnt_add_en || os_cnt_sub_en) begin
      os_cnt <= os_cnt_nxt;
    end
  end

endmodule

/* rd_ig_cmd_decode.sv */
/*
  combinational unpack of a split read command
  ftran and size bit 2 are ignored, a command spans at most 4 atoms
*/
`timescale 1ns/1ps

module rd_ig_cmd_decode (
  input  rd_ig_pkg::rd_cmd_t    req_pd,
  output rd_ig_pkg::ar_cmd_t    ar_cmd,
  output rd_ig_pkg::cq_entry_t  cq_entry,
  output rd_ig_pkg::thread_id_t thread_id
);

  import rd_ig_pkg::*;

  ar_len_t   axi_len;
  mem_addr_t axi_addr;

  // ==============================
  // AR beat
  // ==============================

  // atom aligned, low bits cleared
  assign axi_addr = {req_pd.addr[mem_addr_width-1:atomic_log2], {atomic_log2{1'b0}}};

  // commands never span more than 4 atoms
  assign axi_len = req_pd.size[1:0];

  always_comb begin
    ar_cmd.axid = req_pd.axid;
    ar_cmd.addr = axi_addr;
    ar_cmd.len  = axi_len;
  end

  // ==============================
  // context entry
  // ==============================

  // egress side rebuilds the data order from these
  always_comb begin
    cq_entry.lens    = axi_len;
    cq_entry.swizzle = req_pd.swizzle;
    cq_entry.odd     = req_pd.odd;
    cq_entry.ltran   = req_pd.ltran;
  end

  // ==============================
  // thread lookup
  // ==============================

  // unknown axid falls to thread 0
  always_comb begin
    thread_id = '0;
    // walk down so the lowest matching position wins
    for (int i = num_read_clients - 1; i >= 0; i--) begin
      if (req_pd.axid == client_remap[i]) begin
        thread_id = thread_id_t'(i);
      end
    end
  end

endmodule

/* rd_ig_ar_skid_pipe.sv */
/*
  one stage valid/ready pipe, skid buffer then bubble-collapsing register
  in_ready is a flop, no comb path from out_ready
*/
`timescale 1ns/1ps

module rd_ig_ar_skid_pipe (
  input  logic               nvdla_core_clk,
  input  logic               nvdla_core_rstn,
  input  logic               in_valid,
  output logic               in_ready,
  input  rd_ig_pkg::ar_cmd_t in_cmd,
  output logic               out_valid,
  input  logic               out_ready,
  output rd_ig_pkg::ar_cmd_t out_cmd
);

  import rd_ig_pkg::*;

  logic    skid_catch;
  logic    skid_ready;
  logic    skid_valid;
  ar_cmd_t skid_data;
  logic    skid_pipe_valid;
  logic    skid_pipe_ready;
  ar_cmd_t skid_pipe_data;
  logic    pipe_valid;
  logic    pipe_ready_bc;
  ar_cmd_t pipe_data;

  // ==============================
  // skid stage
  // ==============================

  // beat arrives while we still said ready but the next stage is stalled
  assign skid_catch = in_valid && in_ready && !skid_pipe_ready;

  // a full skid frees once the next stage takes it
  assign skid_ready = skid_valid ? skid_pipe_ready : !skid_catch;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      skid_valid <= 1'b0;
      in_ready   <= 1'b1;
    end else begin
      skid_valid <= skid_valid ? !skid_pipe_ready : skid_catch;
      in_ready   <= skid_ready;
    end
  end

  // skid payload, written on a catch
  always_ff @(posedge nvdla_core_clk) begin
    if (skid_catch) begin
      skid_data <= in_cmd;
    end
  end

  // pass-through while ready, else drain the skid
  assign skid_pipe_valid = in_ready ? in_valid : skid_valid;
  assign skid_pipe_data  = in_ready ? in_cmd : skid_data;

  // ==============================
  // output register
  // ==============================

  // empty register takes a beat even when out_ready is low
  assign pipe_ready_bc   = out_ready || !pipe_valid;
  assign skid_pipe_ready = pipe_ready_bc;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      pipe_valid <= 1'b0;
    end else if (pipe_ready_bc) begin
      pipe_valid <= skid_pipe_valid;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (pipe_ready_bc && skid_pipe_valid) begin
      pipe_data <= skid_pipe_data;
    end
  end

  assign out_valid = pipe_valid;
  assign out_cmd   = pipe_data;

endmodule

/* rd_ig_cvt.sv */
/*
  read request ingress converter, one command in gives one AR beat and one cq write
  reg2dp_rd_os_cnt must stay static while reads are in flight
*/
`timescale 1ns/1ps

module rd_ig_cvt (
  input  logic                   nvdla_core_clk,
  input  logic                   nvdla_core_rstn,
  // split read commands
  input  logic                   req_valid,
  output logic                   req_ready,
  input  rd_ig_pkg::rd_cmd_t     req_pd,
  // context queue write
  output logic                   cq_wr_pvld,
  input  logic                   cq_wr_prdy,
  output rd_ig_pkg::thread_id_t  cq_wr_thread_id,
  output rd_ig_pkg::cq_entry_t   cq_wr_pd,
  // read address channel
  output logic                   ar_valid,
  input  logic                   ar_ready,
  output rd_ig_pkg::ar_cmd_t     ar_cmd,
  // beat retired on the egress side
  input  logic                   eg2ig_axi_vld,
  input  rd_ig_pkg::os_limit_t   reg2dp_rd_os_cnt
);

  import rd_ig_pkg::*;

  // ==============================
  // internal wires
  // ==============================

  ar_cmd_t dec_ar_cmd;
  logic    pipe_in_valid;
  logic    pipe_in_ready;

  // unpack, zero-cycle
  rd_ig_cmd_decode u_cmd_decode (
    .req_pd    (req_pd),
    .ar_cmd    (dec_ar_cmd),
    .cq_entry  (cq_wr_pd),
    .thread_id (cq_wr_thread_id)
  );

  // credits and the cq / pipe interlock
  rd_ig_credit_ctrl u_credit_ctrl (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .req_valid        (req_valid),
    .ar_len           (dec_ar_cmd.len),
    .cq_wr_prdy       (cq_wr_prdy),
    .pipe_in_ready    (pipe_in_ready),
    .eg2ig_axi_vld    (eg2ig_axi_vld),
    .reg2dp_rd_os_cnt (reg2dp_rd_os_cnt),
    .req_ready        (req_ready),
    .cq_wr_pvld       (cq_wr_pvld),
    .pipe_in_valid    (pipe_in_valid)
  );

  // one stage toward AR, no comb path back from ar_ready
  rd_ig_ar_skid_pipe u_ar_pipe (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .in_valid        (pipe_in_valid),
    .in_ready        (pipe_in_ready),
    .in_cmd          (dec_ar_cmd),
    .out_valid       (ar_valid),
    .out_ready       (ar_ready),
    .out_cmd         (ar_cmd)
  );

endmodule

/* tb_rd_ig_cvt.sv */
/*
  testbench for the read ingress converter, stimulus and expected values come from
  rd_ig_stimulus.txt, the limit on its first data word, then 15 words per command
*/
`timescale 1ns/1ps

module tb_rd_ig_cvt;

  import rd_ig_pkg::*;

  localparam int stim_cols    = 15;
  localparam int max_rows     = 64;
  localparam int clk_half     = 20;
  localparam int reset_cycles = 16;
  localparam int hold_cycles  = 20;
  localparam int wait_limit   = 2000;

  logic       nvdla_core_clk;
  logic       nvdla_core_rstn;
  logic       req_valid;
  logic       req_ready;
  rd_cmd_t    req_pd;
  logic       cq_wr_pvld;
  logic       cq_wr_prdy    = 1'b0;
  thread_id_t cq_wr_thread_id;
  cq_entry_t  cq_wr_pd;
  logic       ar_valid;
  logic       ar_ready      = 1'b0;
  ar_cmd_t    ar_cmd;
  logic       eg2ig_axi_vld = 1'b0;
  os_limit_t  reg2dp_rd_os_cnt;

  logic [31:0] stim_mem [0:stim_cols*max_rows];
  integer      seed;
  int          num_rows;
  int          bound;
  int          waited;
  logic        hold_returns = 1'b1;
  // scoreboard counters, all moved on the clock edge
  int acc_cnt   = 0;
  int acc_beats = 0;
  int cq_cnt    = 0;
  int ar_cnt    = 0;
  int ar_beats  = 0;
  int ret_beats = 0;
  int value_errs   = 0;
  int proto_errs   = 0;
  int timeout_errs = 0;

  rd_ig_cvt rd_ig_cvt_inst (
    .nvdla_core_clk   (nvdla_core_clk),
    .nvdla_core_rstn  (nvdla_core_rstn),
    .req_valid        (req_valid),
    .req_ready        (req_ready),
    .req_pd           (req_pd),
    .cq_wr_pvld       (cq_wr_pvld),
    .cq_wr_prdy       (cq_wr_prdy),
    .cq_wr_thread_id  (cq_wr_thread_id),
    .cq_wr_pd         (cq_wr_pd),
    .ar_valid         (ar_valid),
    .ar_ready         (ar_ready),
    .ar_cmd           (ar_cmd),
    .eg2ig_axi_vld    (eg2ig_axi_vld),
    .reg2dp_rd_os_cnt (reg2dp_rd_os_cnt)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #(clk_half) nvdla_core_clk = ~nvdla_core_clk;
  end

  // ==============================
  // error reporting
  // ==============================

  task automatic value_fail(input string name, input logic [63:0] got, input logic [63:0] want);
    value_errs++;
    $display("FAIL t=%0t %s got %0h exp %0h", $time, name, got, want);
  endtask

  task automatic report_error(input string msg);
    proto_errs++;
    $display("ERROR t=%0t %s", $time, msg);
  endtask

  task automatic report_timeout(input string msg);
    timeout_errs++;
    $display("TIMEOUT t=%0t %s", $time, msg);
  endtask

  // ==============================
  // stimulus rows
  // ==============================

  // columns 0..6 command, 7..9 AR beat, 10 thread, 11..14 cq entry
  function automatic rd_cmd_t row_cmd(input int r);
    rd_cmd_t cmd;
    int      base;
    base        = 1 + r * stim_cols;
    cmd.ftran   = stim_mem[base][0];
    cmd.ltran   = stim_mem[base+1][0];
    cmd.odd     = stim_mem[base+2][0];
    cmd.swizzle = stim_mem[base+3][0];
    cmd.size    = stim_mem[base+4][2:0];
    cmd.addr    = stim_mem[base+5];
    cmd.axid    = stim_mem[base+6][3:0];
    return cmd;
  endfunction

  function automatic int exp_beats(input int r);
    return int'(stim_mem[1 + r * stim_cols + 8][1:0]) + 1;
  endfunction

  task automatic check_ar(input int r);
    int base;
    base = 1 + r * stim_cols;
    assert (ar_cmd.addr == stim_mem[base+7])
      else value_fail("ar_cmd.addr", ar_cmd.addr, stim_mem[base+7]);
    assert (ar_cmd.addr[atomic_log2-1:0] == '0)
      else value_fail("ar_cmd.addr low bits", ar_cmd.addr, 0);
    assert (ar_cmd.len == stim_mem[base+8][1:0])
      else value_fail("ar_cmd.len", ar_cmd.len, stim_mem[base+8]);
    assert (ar_cmd.axid == stim_mem[base+9][3:0])
      else value_fail("ar_cmd.axid", ar_cmd.axid, stim_mem[base+9]);
  endtask

  task automatic check_cq(input int r);
    int base;
    base = 1 + r * stim_cols;
    assert (cq_wr_thread_id == stim_mem[base+10][3:0])
      else value_fail("cq_wr_thread_id", cq_wr_thread_id, stim_mem[base+10]);
    assert (cq_wr_pd.ltran == stim_mem[base+11][0])
      else value_fail("cq_wr_pd.ltran", cq_wr_pd.ltran, stim_mem[base+11]);
    assert (cq_wr_pd.odd == stim_mem[base+12][0])
      else value_fail("cq_wr_pd.odd", cq_wr_pd.odd, stim_mem[base+12]);
    assert (cq_wr_pd.swizzle == stim_mem[base+13][0])
      else value_fail("cq_wr_pd.swizzle", cq_wr_pd.swizzle, stim_mem[base+13]);
    assert (cq_wr_pd.lens == stim_mem[base+14][1:0])
      else value_fail("cq_wr_pd.lens", cq_wr_pd.lens, stim_mem[base+14]);
  endtask

  // ==============================
  // monitors and scoreboards
  // ==============================

  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      // command, cq write and pipe entry are one event
      assert ((req_valid && req_ready) == (cq_wr_pvld && cq_wr_prdy))
        else report_error("command and context write did not happen in the same cycle");
      if (cq_wr_pvld && cq_wr_prdy) begin
        assert (cq_cnt < num_rows) else report_error("context write with no command left");
        if (cq_cnt < num_rows) begin
          check_cq(cq_cnt);
        end
        cq_cnt <= cq_cnt + 1;
      end
      if (req_valid && req_ready && acc_cnt < num_rows) begin
        acc_cnt   <= acc_cnt + 1;
        acc_beats <= acc_beats + exp_beats(acc_cnt);
      end
      // tb count lags behind the dut only on the safe side
      assert (acc_beats - ret_beats <= bound)
        else report_error("outstanding beats above the limit");
      // credit full while returns are held
      if (hold_returns && req_valid && acc_cnt < num_rows &&
          acc_beats + exp_beats(acc_cnt) - ret_beats > bound) begin
        assert (!req_ready) else report_error("command accepted past the credit limit");
      end
      if (ar_valid && ar_ready) begin
        assert (ar_cnt < acc_cnt) else report_error("AR beat with no accepted command");
        if (ar_cnt < acc_cnt) begin
          check_ar(ar_cnt);
        end
        ar_cnt   <= ar_cnt + 1;
        ar_beats <= ar_beats + exp_beats(ar_cnt);
      end
    end
  end

  // random back-pressure and returns, one seed for all of it
  always @(posedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      ar_ready   <= ($random(seed) & 3) != 0;
      cq_wr_prdy <= ($random(seed) & 3) != 0;
      if (!hold_returns && ret_beats < ar_beats && ($random(seed) & 1)) begin
        eg2ig_axi_vld <= 1'b1;
        ret_beats     <= ret_beats + 1;
      end else begin
        eg2ig_axi_vld <= 1'b0;
      end
    end
  end

  // ==============================
  // drivers
  // ==============================

  task automatic drive_commands;
    int   r;
    int   cnt;
    logic done;
    r = 0;
    while (r < num_rows) begin
      req_valid <= 1'b1;
      req_pd    <= row_cmd(r);
      done = 1'b0;
      cnt  = 0;
      while (!done && cnt < wait_limit) begin
        @(posedge nvdla_core_clk);
        cnt++;
        done = req_ready;
      end
      assert (done) else begin
        report_timeout("command was never accepted");
        r = num_rows;
      end
      r++;
    end
    req_valid <= 1'b0;
  endtask

  // hold returns until the credit limit stalls the command port
  task automatic release_returns;
    int cnt;
    int blocked;
    cnt     = 0;
    blocked = 0;
    while (blocked < hold_cycles && cnt < wait_limit) begin
      @(posedge nvdla_core_clk);
      cnt++;
      if (req_valid && acc_cnt < num_rows && acc_beats + exp_beats(acc_cnt) - ret_beats > bound)
        blocked++;
      else
        blocked = 0;
    end
    assert (blocked >= hold_cycles)
      else report_timeout("credit limit was never reached with returns held");
    hold_returns <= 1'b0;
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    seed            = 32'h4761;
    nvdla_core_rstn = 1'b0;
    req_valid       = 1'b0;
    req_pd          = '0;
    $readmemh("rd_ig_stimulus.txt", stim_mem);
    reg2dp_rd_os_cnt = stim_mem[0][7:0];
    bound            = int'(reg2dp_rd_os_cnt) + 1;
    num_rows = 0;
    while (num_rows < max_rows && !$isunknown(stim_mem[1 + num_rows * stim_cols])) num_rows++;
    assert (num_rows > 0) else report_error("no commands found in the stimulus file");
    // flops settle on the first edge under reset
    @(posedge nvdla_core_clk);
    repeat (reset_cycles - 1) begin
      @(posedge nvdla_core_clk);
      assert (ar_valid === 1'b0) else report_error("ar_valid high during reset");
    end
    nvdla_core_rstn <= 1'b1;
    fork
      drive_commands();
      release_returns();
    join
    // drain beats and returns
    waited = 0;
    while ((ar_cnt < num_rows || ret_beats < ar_beats) && waited < wait_limit) begin
      @(posedge nvdla_core_clk);
      waited++;
    end
    assert (waited < wait_limit) else report_timeout("AR beats or returns did not drain");
    repeat (4) @(posedge nvdla_core_clk);
    assert (ar_valid === 1'b0) else report_error("ar_valid still high after the drain");
    assert (acc_cnt == num_rows) else value_fail("accepted commands", acc_cnt, num_rows);
    assert (cq_cnt == acc_cnt) else value_fail("cq_wr handshakes", cq_cnt, acc_cnt);
    assert (ar_cnt == acc_cnt) else value_fail("AR handshakes", ar_cnt, acc_cnt);
    $display("commands %0d, value errors %0d, protocol errors %0d, timeouts %0d",
             num_rows, value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* rd_ig_stimulus.txt */
// first word is the outstanding limit, then one command per line, all hex
// ftran ltran odd swizzle size addr axid | exp: addr len axid thread ltran odd swizzle lens
// first three commands fill limit plus one beats exactly
08
1 0 0 0 3 10000020 0   10000020 3 0 0 0 0 0 3
0 0 1 0 2 1000003f 8   10000020 2 8 1 0 1 0 2
0 1 0 1 1 20000047 9   20000040 1 9 2 1 0 1 1
1 1 1 1 0 abcdef12 3   abcdef00 0 3 3 1 1 1 0
0 0 0 0 7 0000ffff 2   0000ffe0 3 2 4 0 0 0 3
0 1 1 0 5 12345678 4   12345660 1 4 5 1 1 0 1
1 0 0 1 4 deadbeef 1   deadbee0 0 1 6 0 0 1 0
0 0 1 1 6 fffffff1 5   ffffffe0 2 5 7 0 1 1 2
0 1 0 0 3 00000000 7   00000000 3 7 8 1 0 0 3
1 1 0 1 2 0000101f 6   00001000 2 6 9 1 0 1 2
0 0 0 1 1 55555555 a   55555540 1 a 0 0 0 1 1
0 1 1 1 0 aaaaaaaa f   aaaaaaa0 0 f 0 1 1 1 0
1 0 1 0 3 80000060 c   80000060 3 c 0 0 1 0 3
0 0 0 0 1 7fffffe5 0   7fffffe0 1 0 0 0 0 0 1
0 1 0 1 2 01234567 8   01234560 2 8 1 1 0 1 2
1 1 1 0 3 c0ffee3c 9   c0ffee20 3 9 2 1 1 0 3
0 0 1 0 0 00000080 3   00000080 0 3 3 0 1 0 0
0 1 0 0 7 fedcba98 2   fedcba80 3 2 4 1 0 0 3
1 0 0 1 1 13579bdf 4   13579bc0 1 4 5 0 0 1 1
0 0 1 1 2 2468ace0 1   2468ace0 2 1 6 0 1 1 2
0 1 1 0 3 0f0f0f0f 5   0f0f0f00 3 5 7 1 1 0 3
1 1 0 0 0 f0f0f0f0 6   f0f0f0e0 0 6 9 1 0 0 0
0 0 0 1 5 00000001 7   00000000 1 7 8 0 0 1 1
0 1 1 1 2 99999999 b   99999980 2 b 0 1 1 1 2

/* vlog.f */
rd_ig_pkg.sv
rd_ig_credit_ctrl.sv
rd_ig_cmd_decode.sv
rd_ig_ar_skid_pipe.sv
rd_ig_cvt.sv
tb_rd_ig_cvt.sv
